// File: dv/vi_core_patterns.txt
# M line_byte_addr word@+0 word@+4 word@+8 word@+12 | W byte_addr data byte_flag
# R read_byte_addr in issue order | E number_of_W_lines
M 08000 00300513 00E00593 00B51533 12300093
M 08010 00A08233 00452023 00A52223 00500193
M 08020 00110113 00310463 FF9FF06F 00252423
M 08030 0080036F 00100393 00652623 00450823
M 08040 00052403 00852A23 01052483 00952C23
M 08050 00000000 00000000 00000000 00000000
W 0C000 0000C123 0
W 0C004 0000C000 0
W 0C008 00000005 0
W 0C00C 00008034 0
W 0C010 00000023 1
W 0C014 0000C123 0
W 0C018 00000023 0
R 08000
R 08010
R 08020
R 08030
R 08040
R 0C000
R 0C010
R 08050
E 7

// File: files.f
+incdir+source
source/vi_pkg.sv
source/vi_regfile.sv
source/vi_alu.sv
source/vi_control.sv
source/vi_fetch.sv
source/vi_lsu.sv
source/vi_core.sv
dv/vi_core_tb.sv

// File: Bender.yml
package:
  name: vi_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/vi_pkg.sv
      - source/vi_regfile.sv
      - source/vi_alu.sv
      - source/vi_control.sv
      - source/vi_fetch.sv
      - source/vi_lsu.sv
      - source/vi_core.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/vi_core_tb.sv

// File: dv/vi_core_tb.sv
`timescale 1ns/10ps
`include "vi_config.svh"

module vi_core_tb;

	localparam int LINE_COUNT   = 1 << (`VI_ADDR_W - `VI_LINE_OFF_W);
	localparam int QUIET_CYCLES = 64;

	// execution starts here after reset
	localparam logic [`VI_ADDR_W-1:0] FIRST_FETCH_ADDR = 20'h08000;

	logic                  clk = 1'b0;
	logic                  reset_i;
	logic                  mem_data_ready_i;
	logic [`VI_LINE_W-1:0] mem_data_i;
	logic [`VI_ADDR_W-1:0] mem_addr_i;
	logic                  mem_read_o;
	logic [`VI_ADDR_W-1:0] mem_read_addr_o;
	logic                  mem_write_enable_o;
	logic                  mem_write_byte_o;
	logic [`VI_ADDR_W-1:0] mem_write_addr_o;
	logic [31:0]           mem_write_data_o;

	// unloaded lines of the line memory read as zero words and so halt the core
	bit [`VI_LINE_W-1:0]   mem [LINE_COUNT];

	logic [`VI_ADDR_W-1:0] exp_w_addr [$];
	logic [31:0]           exp_w_data [$];
	logic                  exp_w_byte [$];
	logic [`VI_ADDR_W-1:0] exp_r_addr [$];
	int                    exp_w_count;
	int                    writes_seen;
	int                    reads_seen;
	int                    cycles;
	int                    timeout_limit;

	// memory model state
	logic                  pending;
	logic [`VI_ADDR_W-1:0] pending_addr;
	int                    wait_left;
	logic                  ready_next;
	logic [`VI_LINE_W-1:0] data_next;
	logic [`VI_ADDR_W-1:0] addr_next;
	logic [31:0]           rng_state;

	vi_core u_vi_core (
		.clk                (clk),
		.reset_i            (reset_i),
		.mem_data_ready_i   (mem_data_ready_i),
		.mem_data_i         (mem_data_i),
		.mem_addr_i         (mem_addr_i),
		.mem_read_o         (mem_read_o),
		.mem_read_addr_o    (mem_read_addr_o),
		.mem_write_enable_o (mem_write_enable_o),
		.mem_write_byte_o   (mem_write_byte_o),
		.mem_write_addr_o   (mem_write_addr_o),
		.mem_write_data_o   (mem_write_data_o)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fail_now();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic fail_plain(input string msg);
		$display("Error: %s (time %0t ns)", msg, $time);
		fail_now();
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
		fail_now();
	endtask

	task automatic check_read_addr(input logic [`VI_ADDR_W-1:0] exp_addr,
		input logic [`VI_ADDR_W-1:0] act_addr);
		if (act_addr !== exp_addr) begin
			report_mismatch("mem_read_addr_o", exp_addr, act_addr);
		end
	endtask

	task automatic check_write(
		input logic [`VI_ADDR_W-1:0] exp_addr,
		input logic [31:0]           exp_data,
		input logic                  exp_byte,
		input logic [`VI_ADDR_W-1:0] act_addr,
		input logic [31:0]           act_data,
		input logic                  act_byte
	);
		if (act_addr !== exp_addr) begin
			report_mismatch("mem_write_addr_o", exp_addr, act_addr);
		end
		if (act_byte !== exp_byte) begin
			report_mismatch("mem_write_byte_o", exp_byte, act_byte);
		end
		// a byte store only carries its value in the low byte
		if (exp_byte) begin
			if (act_data[7:0] !== exp_data[7:0]) begin
				report_mismatch("mem_write_data_o[7:0]", exp_data[7:0], act_data[7:0]);
			end
		end else if (act_data !== exp_data) begin
			report_mismatch("mem_write_data_o", exp_data, act_data);
		end
	endtask

	task automatic apply_write(input logic [`VI_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic is_byte);
		logic [`VI_ADDR_W-1:0] a;
		for (int i = 0; i < (is_byte ? 1 : 4); i++) begin
			a = addr + i;
			mem[a[`VI_ADDR_W-1:`VI_LINE_OFF_W]][{a[`VI_LINE_OFF_W-1:0], 3'b000} +: 8] =
				data[i*8 +: 8];
		end
	endtask

	task automatic note_read(input logic [`VI_ADDR_W-1:0] addr);
		if (reads_seen == 0) begin
			check_read_addr(FIRST_FETCH_ADDR, addr);
		end
		if (reads_seen >= exp_r_addr.size()) begin
			fail_plain($sformatf("read of address %h beyond the expected reads", addr));
		end else begin
			check_read_addr(exp_r_addr[reads_seen], addr);
		end
		reads_seen++;
	endtask

	task automatic load_patterns();
		int                    fd;
		int                    code;
		string                 kind;
		string                 rest;
		logic [`VI_ADDR_W-1:0] addr;
		logic [31:0]           w0;
		logic [31:0]           w1;
		logic [31:0]           w2;
		logic [31:0]           w3;
		logic                  flag;
		fd = $fopen("dv/vi_core_patterns.txt", "r");
		if (fd == 0) begin
			fail_plain("cannot open dv/vi_core_patterns.txt");
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", kind);
			if (code == 1) begin
				if (kind[0] == "#") begin
					code = $fgets(rest, fd);
				end else if (kind == "M") begin
					code = $fscanf(fd, "%h %h %h %h %h", addr, w0, w1, w2, w3);
					mem[addr[`VI_ADDR_W-1:`VI_LINE_OFF_W]] = {w3, w2, w1, w0};
				end else if (kind == "W") begin
					code = $fscanf(fd, "%h %h %h", addr, w0, flag);
					exp_w_addr.push_back(addr);
					exp_w_data.push_back(w0);
					exp_w_byte.push_back(flag);
				end else if (kind == "R") begin
					code = $fscanf(fd, "%h", addr);
					exp_r_addr.push_back(addr);
				end else if (kind == "E") begin
					code = $fscanf(fd, "%d", exp_w_count);
				end else begin
					fail_plain($sformatf("unknown record '%s' in the pattern file", kind));
				end
			end
		end
		$fclose(fd);
		if (exp_w_count != exp_w_addr.size()) begin
			fail_plain("write count in the E line does not match the W lines");
		end
	endtask

	// inputs change 1 ns after the rising edge
	always @(posedge clk) begin
		#1;
		mem_data_ready_i = ready_next;
		mem_data_i       = data_next;
		mem_addr_i       = addr_next;
	end

	// outputs are sampled mid cycle where they are stable
	always @(negedge clk) begin
		if (reset_i) begin
			if (mem_read_o !== 1'b0 || mem_write_enable_o !== 1'b0) begin
				fail_plain("read or write active during reset");
			end
		end else begin
			cycles++;
			if (cycles > timeout_limit) begin
				$display("Error: no progress after %0d cycles, core state %s",
					cycles, u_vi_core.u_control.state_q.name());
				fail_now();
			end
			if (mem_read_o && mem_write_enable_o) begin
				fail_plain("read and write active in the same cycle");
			end
			if (mem_write_enable_o) begin
				if (reads_seen == 0) begin
					fail_plain("write issued before the first fetch");
				end
				if (writes_seen >= exp_w_count) begin
					fail_plain($sformatf("extra write to %h after the last expected write",
						mem_write_addr_o));
				end
				check_write(exp_w_addr[writes_seen], exp_w_data[writes_seen],
					exp_w_byte[writes_seen], mem_write_addr_o, mem_write_data_o,
					mem_write_byte_o);
				apply_write(mem_write_addr_o, mem_write_data_o, mem_write_byte_o);
				writes_seen++;
			end
			if (mem_data_ready_i) begin
				// the core takes the line at the coming edge
				if (!mem_read_o) begin
					fail_plain("read request dropped while ready was high");
				end
				ready_next = 1'b0;
				data_next  = '0;
				addr_next  = '0;
				pending    = 1'b0;
			end else begin
				if (pending) begin
					if (!mem_read_o) begin
						fail_plain("read request dropped before the memory answered");
					end
					if (mem_read_addr_o !== pending_addr) begin
						fail_plain("read address changed while the request was held");
					end
				end else if (mem_read_o) begin
					note_read(mem_read_addr_o);
					pending      = 1'b1;
					pending_addr = mem_read_addr_o;
					rng_state    = xorshift32(rng_state);
					wait_left    = (rng_state % 3) + 1;
				end
				if (pending) begin
					if (wait_left <= 1) begin
						ready_next = 1'b1;
						addr_next  = pending_addr;
						data_next  = mem[pending_addr[`VI_ADDR_W-1:`VI_LINE_OFF_W]];
					end else begin
						wait_left--;
					end
				end
			end
		end
	end

	initial begin
		reset_i          = 1'b1;
		mem_data_ready_i = 1'b0;
		mem_data_i       = '0;
		mem_addr_i       = '0;
		ready_next       = 1'b0;
		data_next        = '0;
		addr_next        = '0;
		pending          = 1'b0;
		pending_addr     = '0;
		wait_left        = 0;
		rng_state        = 32'd98467;
		writes_seen      = 0;
		reads_seen       = 0;
		cycles           = 0;
		exp_w_count      = 0;
		load_patterns();
		timeout_limit = `VI_TIMEOUT_PER_WRITE * exp_w_count + `VI_TIMEOUT_MARGIN;
		repeat (8) @(posedge clk);
		#1;
		reset_i = 1'b0;
		while (writes_seen < exp_w_count || reads_seen < exp_r_addr.size()) begin
			@(posedge clk);
		end
		// the halted core must stay silent on the port from here on
		repeat (QUIET_CYCLES) @(posedge clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: source/vi_core.sv
`timescale 1ns/10ps
`include "vi_config.svh"

module vi_core import vi_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  mem_data_ready_i,
	input  logic [`VI_LINE_W-1:0] mem_data_i,
	input  logic [`VI_ADDR_W-1:0] mem_addr_i,
	output logic                  mem_read_o,
	output logic [`VI_ADDR_W-1:0] mem_read_addr_o,
	output logic                  mem_write_enable_o,
	output logic                  mem_write_byte_o,
	output logic [`VI_ADDR_W-1:0] mem_write_addr_o,
	output logic [31:0]           mem_write_data_o
);

	instr_u                instr;
	logic                  instr_valid;
	logic                  fetch_req;
	logic                  fetch_read;
	logic [`VI_ADDR_W-1:0] fetch_addr;
	logic                  read_accept;
	logic                  lsu_read;
	logic                  lsu_write;
	logic                  rf_we;
	wsel_e                 rf_wsel;
	alu_op_e               alu_op;
	pc_sel_e               pc_sel;
	logic                  halt;
	logic                  alu_zero;
	logic [31:0]           alu_result;
	logic [31:0]           rdata1;
	logic [31:0]           rdata2;
	logic [31:0]           load_data;
	logic [31:0]           rf_wdata;
	logic [`VI_ADDR_W-1:0] branch_target;
	logic [`VI_ADDR_W-1:0] jump_target;
	logic [`VI_ADDR_W-1:0] pc_q;
	logic [`VI_ADDR_W-1:0] pc_plus4;

	assign pc_plus4 = pc_q + {{(`VI_ADDR_W-3){1'b0}}, 3'd4};

	// program counter, stepped only when control selects a new value
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q <= `VI_RESET_PC;
		end else begin
			case (pc_sel)
				PC_PLUS4:  pc_q <= pc_plus4;
				PC_BRANCH: pc_q <= branch_target;
				PC_JUMP:   pc_q <= jump_target;
				default:   pc_q <= pc_q;
			endcase
		end
	end

	always_comb begin
		case (rf_wsel)
			WSEL_LINK: rf_wdata = {{(32-`VI_ADDR_W){1'b0}}, pc_plus4};
			WSEL_LOAD: rf_wdata = load_data;
			default:   rf_wdata = alu_result;
		endcase
	end

	vi_control u_control (
		.clk           (clk),
		.reset_i       (reset_i),
		.instr_i       (instr),
		.instr_valid_i (instr_valid),
		.load_done_i   (read_accept),
		.alu_zero_i    (alu_zero),
		.fetch_req_o   (fetch_req),
		.lsu_read_o    (lsu_read),
		.lsu_write_o   (lsu_write),
		.rf_we_o       (rf_we),
		.rf_wsel_o     (rf_wsel),
		.alu_op_o      (alu_op),
		.pc_sel_o      (pc_sel),
		.halt_o        (halt)
	);

	vi_regfile u_regfile (
		.clk      (clk),
		.reset_i  (reset_i),
		.rs1_i    (instr.r.rs1),
		.rs2_i    (instr.r.rs2),
		.rd_i     (instr.r.rd),
		.we_i     (rf_we),
		.wdata_i  (rf_wdata),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	vi_alu u_alu (
		.a_i             (rdata1),
		.b_i             (rdata2),
		.instr_i         (instr),
		.pc_i            (pc_q),
		.alu_op_i        (alu_op),
		.result_o        (alu_result),
		.zero_o          (alu_zero),
		.branch_target_o (branch_target),
		.jump_target_o   (jump_target)
	);

	vi_fetch u_fetch (
		.clk              (clk),
		.reset_i          (reset_i),
		.pc_i             (pc_q),
		.fetch_req_i      (fetch_req),
		.line_i           (mem_data_i),
		.line_ready_i     (read_accept),
		.store_hit_addr_i (mem_write_addr_o),
		.store_i          (mem_write_enable_o),
		.read_o           (fetch_read),
		.read_addr_o      (fetch_addr),
		.instr_o          (instr),
		.instr_valid_o    (instr_valid)
	);

	vi_lsu u_lsu (
		.clk                (clk),
		.reset_i            (reset_i),
		.base_i             (rdata1),
		.store_val_i        (rdata2),
		.instr_i            (instr),
		.read_i             (lsu_read),
		.write_i            (lsu_write),
		.fetch_read_i       (fetch_read),
		.fetch_addr_i       (fetch_addr),
		.mem_data_ready_i   (mem_data_ready_i),
		.mem_data_i         (mem_data_i),
		.mem_addr_i         (mem_addr_i),
		.mem_read_o         (mem_read_o),
		.mem_read_addr_o    (mem_read_addr_o),
		.mem_write_enable_o (mem_write_enable_o),
		.mem_write_byte_o   (mem_write_byte_o),
		.mem_write_addr_o   (mem_write_addr_o),
		.mem_write_data_o   (mem_write_data_o),
		.load_data_o        (load_data),
		.load_done_o        (read_accept)
	);

	// once halted the core must stay silent on the memory port
	a_halt_quiet: assert property (@(posedge clk) disable iff (reset_i)
		halt |-> !mem_read_o && !mem_write_enable_o);

endmodule

// File: source/vi_lsu.sv
`timescale 1ns/10ps
`include "vi_config.svh"

module vi_lsu import vi_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic [31:0]           base_i,
	input  logic [31:0]           store_val_i,
	input  instr_u                instr_i,
	input  logic                  read_i,
	input  logic                  write_i,
	input  logic                  fetch_read_i,
	input  logic [`VI_ADDR_W-1:0] fetch_addr_i,
	input  logic                  mem_data_ready_i,
	input  logic [`VI_LINE_W-1:0] mem_data_i,
	input  logic [`VI_ADDR_W-1:0] mem_addr_i,
	output logic                  mem_read_o,
	output logic [`VI_ADDR_W-1:0] mem_read_addr_o,
	output logic                  mem_write_enable_o,
	output logic                  mem_write_byte_o,
	output logic [`VI_ADDR_W-1:0] mem_write_addr_o,
	output logic [31:0]           mem_write_data_o,
	output logic [31:0]           load_data_o,
	output logic                  load_done_o
);

	logic [11:0]           offset;
	logic [`VI_ADDR_W-1:0] eff_addr;
	logic                  is_byte;

	assign offset = (instr_i.s.opcode == OPC_STORE) ? {instr_i.s.imm_hi, instr_i.s.imm_lo}
		: instr_i.i.imm;
	assign eff_addr = base_i[`VI_ADDR_W-1:0] + {{(`VI_ADDR_W-12){offset[11]}}, offset};
	assign is_byte  = (instr_i.s.funct3 == F3_BYTE);

	// fetch and load never overlap, so a plain mux shares the read port
	assign mem_read_o      = read_i | fetch_read_i;
	assign mem_read_addr_o = read_i ? eff_addr : fetch_addr_i;

	// accept only data returned for the address currently requested
	// the fetch buffer takes this as its line ready too
	assign load_done_o = mem_read_o && mem_data_ready_i && (mem_addr_i == mem_read_addr_o);
	assign load_data_o = mem_data_i[{mem_read_addr_o[`VI_LINE_OFF_W-1:2], 5'b00000} +: 32];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			mem_write_enable_o <= 1'b0;
		end else begin
			mem_write_enable_o <= write_i;
		end
	end

	always_ff @(posedge clk) begin
		if (write_i) begin
			mem_write_addr_o <= eff_addr;
			mem_write_byte_o <= is_byte;
			mem_write_data_o <= is_byte ? {24'd0, store_val_i[7:0]} : store_val_i;
		end
	end

	a_port_excl: assert property (@(posedge clk) disable iff (reset_i)
		!(mem_read_o && mem_write_enable_o));

endmodule

// File: source/vi_fetch.sv
`timescale 1ns/10ps
`include "vi_config.svh"

module vi_fetch import vi_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic [`VI_ADDR_W-1:0] pc_i,
	input  logic                  fetch_req_i,
	input  logic [`VI_LINE_W-1:0] line_i,
	input  logic                  line_ready_i,
	input  logic [`VI_ADDR_W-1:0] store_hit_addr_i,
	input  logic                  store_i,
	output logic                  read_o,
	output logic [`VI_ADDR_W-1:0] read_addr_o,
	output instr_u                instr_o,
	output logic                  instr_valid_o
);

	localparam int TAG_W = `VI_ADDR_W - `VI_LINE_OFF_W;

	logic [`VI_LINE_W-1:0] line_q;
	logic [TAG_W-1:0]      tag_q;
	logic                  valid_q;
	logic                  store_kill;
	logic                  hit;

	// a store pulse to the buffered line makes it stale in that same cycle
	assign store_kill = store_i && (store_hit_addr_i[`VI_ADDR_W-1:`VI_LINE_OFF_W] == tag_q);
	assign hit = valid_q && !store_kill && (pc_i[`VI_ADDR_W-1:`VI_LINE_OFF_W] == tag_q);

	assign instr_o       = line_q[{pc_i[`VI_LINE_OFF_W-1:2], 5'b00000} +: 32];
	assign instr_valid_o = fetch_req_i && hit;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q <= 1'b0;
			read_o  <= 1'b0;
		end else begin
			if (store_kill) begin
				valid_q <= 1'b0;
			end
			if (read_o && line_ready_i) begin
				read_o  <= 1'b0;
				valid_q <= 1'b1;
			end else if (fetch_req_i && !hit && !read_o) begin
				read_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (read_o && line_ready_i) begin
			line_q <= line_i;
			tag_q  <= read_addr_o[`VI_ADDR_W-1:`VI_LINE_OFF_W];
		end
		if (fetch_req_i && !hit && !read_o) begin
			read_addr_o <= pc_i;
		end
	end

	a_read_held: assert property (@(posedge clk) disable iff (reset_i)
		read_o && !line_ready_i |=> read_o && $stable(read_addr_o));

endmodule

// File: source/vi_control.sv
`timescale 1ns/10ps

module vi_control import vi_pkg::*; (
	input  logic    clk,
	input  logic    reset_i,
	input  instr_u  instr_i,
	input  logic    instr_valid_i,
	input  logic    load_done_i,
	input  logic    alu_zero_i,
	output logic    fetch_req_o,
	output logic    lsu_read_o,
	output logic    lsu_write_o,
	output logic    rf_we_o,
	output wsel_e   rf_wsel_o,
	output alu_op_e alu_op_o,
	output pc_sel_e pc_sel_o,
	output logic    halt_o
);

	core_state_e state_q;
	core_state_e state_d;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= ST_FETCH;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d     = state_q;
		fetch_req_o = 1'b0;
		lsu_read_o  = 1'b0;
		lsu_write_o = 1'b0;
		rf_we_o     = 1'b0;
		rf_wsel_o   = WSEL_ALU;
		alu_op_o    = ALU_PASS_B;
		pc_sel_o    = PC_HOLD;
		case (state_q)
			ST_FETCH: begin
				fetch_req_o = 1'b1;
				if (instr_valid_i) begin
					state_d = ST_EXEC;
				end
			end
			ST_EXEC: begin
				// anything not recognized below stops the core
				state_d = ST_HALT;
				case (instr_i.r.opcode)
					OPC_OP_IMM: begin
						if (instr_i.i.funct3 == F3_ADD) begin
							alu_op_o = ALU_ADD;
							rf_we_o  = 1'b1;
							pc_sel_o = PC_PLUS4;
							state_d  = ST_FETCH;
						end
					end
					OPC_OP: begin
						if (instr_i.r.funct7 == 7'd0 &&
							(instr_i.r.funct3 == F3_ADD || instr_i.r.funct3 == F3_SLL)) begin
							alu_op_o = (instr_i.r.funct3 == F3_SLL) ? ALU_SLL : ALU_ADD;
							rf_we_o  = 1'b1;
							pc_sel_o = PC_PLUS4;
							state_d  = ST_FETCH;
						end
					end
					OPC_BRANCH: begin
						if (instr_i.b.funct3 == F3_BEQ) begin
							pc_sel_o = alu_zero_i ? PC_BRANCH : PC_PLUS4;
							state_d  = ST_FETCH;
						end
					end
					OPC_JAL: begin
						rf_we_o   = 1'b1;
						rf_wsel_o = WSEL_LINK;
						pc_sel_o  = PC_JUMP;
						state_d   = ST_FETCH;
					end
					OPC_LOAD: begin
						if (instr_i.i.funct3 == F3_WORD) begin
							state_d = ST_LOAD_WAIT;
						end
					end
					OPC_STORE: begin
						if (instr_i.s.funct3 == F3_WORD || instr_i.s.funct3 == F3_BYTE) begin
							state_d = ST_STORE;
						end
					end
					default: begin
						state_d = ST_HALT;
					end
				endcase
			end
			ST_LOAD_WAIT: begin
				// the read stays up until the memory returns our line
				lsu_read_o = 1'b1;
				if (load_done_i) begin
					rf_we_o   = 1'b1;
					rf_wsel_o = WSEL_LOAD;
					pc_sel_o  = PC_PLUS4;
					state_d   = ST_FETCH;
				end
			end
			ST_STORE: begin
				lsu_write_o = 1'b1;
				pc_sel_o    = PC_PLUS4;
				state_d     = ST_FETCH;
			end
			default: begin
				state_d = ST_HALT;
			end
		endcase
	end

	assign halt_o = (state_q == ST_HALT);

	a_lsu_excl: assert property (@(posedge clk) disable iff (reset_i)
		!(lsu_read_o && lsu_write_o));

	a_no_we_in_fetch: assert property (@(posedge clk) disable iff (reset_i)
		state_q == ST_FETCH |-> !rf_we_o);

endmodule

// File: source/vi_alu.sv
`timescale 1ns/10ps
`include "vi_config.svh"

module vi_alu import vi_pkg::*; (
	input  logic [31:0]           a_i,
	input  logic [31:0]           b_i,
	input  instr_u                instr_i,
	input  logic [`VI_ADDR_W-1:0] pc_i,
	input  alu_op_e               alu_op_i,
	output logic [31:0]           result_o,
	output logic                  zero_o,
	output logic [`VI_ADDR_W-1:0] branch_target_o,
	output logic [`VI_ADDR_W-1:0] jump_target_o
);

	logic [31:0] i_imm;
	logic [31:0] b_imm;
	logic [31:0] j_imm;
	logic [31:0] op_b;

	assign i_imm = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};

	assign b_imm = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
		instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};

	// jump bits 19:12 sit where the branch view has rs1 and funct3
	assign j_imm = {{11{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.rs1,
		instr_i.b.funct3, instr_i.b.rs2[0], instr_i.b.imm_10_5, instr_i.b.rs2[4:1], 1'b0};

	// register operand only for the R format, the immediate otherwise
	assign op_b = (instr_i.r.opcode == OPC_OP) ? b_i : i_imm;

	always_comb begin
		case (alu_op_i)
			ALU_ADD: result_o = a_i + op_b;
			ALU_SLL: result_o = a_i << op_b[4:0];
			default: result_o = op_b;
		endcase
	end

	assign zero_o = (a_i == b_i);

	assign branch_target_o = pc_i + b_imm[`VI_ADDR_W-1:0];
	assign jump_target_o   = pc_i + j_imm[`VI_ADDR_W-1:0];

endmodule

// File: source/vi_regfile.sv
`timescale 1ns/10ps

module vi_regfile (
	input  logic        clk,
	input  logic        reset_i,
	input  logic [4:0]  rs1_i,
	input  logic [4:0]  rs2_i,
	input  logic [4:0]  rd_i,
	input  logic        we_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rdata1_o,
	output logic [31:0] rdata2_o
);

	// x0 has no storage, it is decoded as zero on read
	logic [31:0] regs_q [1:31];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= 32'd0;
			end
		end else if (we_i && rd_i != 5'd0) begin
			regs_q[rd_i] <= wdata_i;
		end
	end

	assign rdata1_o = (rs1_i == 5'd0) ? 32'd0 : regs_q[rs1_i];
	assign rdata2_o = (rs2_i == 5'd0) ? 32'd0 : regs_q[rs2_i];

endmodule

// File: source/vi_pkg.sv
package vi_pkg;

	// major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [2:0] {
		F3_ADD = 3'b000,
		F3_SLL = 3'b001
	} funct3_alu_e;

	typedef enum logic [2:0] {
		F3_BEQ = 3'b000
	} funct3_br_e;

	typedef enum logic [2:0] {
		F3_BYTE = 3'b000,
		F3_WORD = 3'b010
	} funct3_mem_e;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SLL,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		PC_HOLD,
		PC_PLUS4,
		PC_BRANCH,
		PC_JUMP
	} pc_sel_e;

	// source of the register write data
	typedef enum logic [1:0] {
		WSEL_ALU,
		WSEL_LINK,
		WSEL_LOAD
	} wsel_e;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_EXEC,
		ST_LOAD_WAIT,
		ST_STORE,
		ST_HALT
	} core_state_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} s_fmt_t;

	// branch layout, the jump immediate is rebuilt from the same fields
	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
	} instr_u;

endpackage

// File: source/vi_config.svh
`ifndef VI_CONFIG_SVH
`define VI_CONFIG_SVH

// byte address width of the memory port
`define VI_ADDR_W 20

// one memory line carries four instruction or data words
`define VI_LINE_W 128

// byte offset bits inside a line, the tag is everything above
`define VI_LINE_OFF_W 4

// first fetch address after reset
`define VI_RESET_PC 20'h08000

// the run is declared stuck after this many cycles per expected write
`define VI_TIMEOUT_PER_WRITE 200

// fixed slack added on top of the per-write budget
`define VI_TIMEOUT_MARGIN 500

`endif
